// ==== Bender.yml ====
package:
  name: snake_game

sources:
  - source/snake_pkg.sv
  - source/tick_gen.sv
  - source/key_decoder.sv
  - source/game_fsm.sv
  - source/snake_body.sv
  - source/segment_order.sv
  - source/snake_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/snake_tb.sv

// ==== bench/snake_tb_table.svh ====
// Snake testbench stimulus table
// columns: key sent before the tick (00 none), head x, head y, tail x, tail y, blank

task automatic fill_table();
    rows[0]  = '{8'h00,      6'd3, 6'd48, 6'd0, 6'd48, 1'b0};   // idle row
    rows[1]  = '{8'h00,      6'd3, 6'd48, 6'd0, 6'd48, 1'b0};
    rows[2]  = '{8'h55,      6'd3, 6'd48, 6'd0, 6'd48, 1'b0};   // unknown code
    rows[3]  = '{key_start,  6'd3, 6'd23, 6'd0, 6'd23, 1'b0};
    rows[4]  = '{8'h00,      6'd3, 6'd23, 6'd0, 6'd23, 1'b0};   // start row held
    rows[5]  = '{8'h00,      6'd4, 6'd23, 6'd1, 6'd23, 1'b0};
    rows[6]  = '{8'h00,      6'd5, 6'd23, 6'd2, 6'd23, 1'b0};
    rows[7]  = '{key_up,     6'd5, 6'd22, 6'd3, 6'd23, 1'b0};   // turn up
    rows[8]  = '{key_right,  6'd5, 6'd21, 6'd4, 6'd23, 1'b0};   // locked
    rows[9]  = '{key_left,   6'd5, 6'd20, 6'd5, 6'd23, 1'b0};   // locked
    rows[10] = '{key_right,  6'd5, 6'd19, 6'd5, 6'd22, 1'b0};   // last locked step
    rows[11] = '{key_down,   6'd5, 6'd18, 6'd5, 6'd21, 1'b0};   // reverse ignored
    rows[12] = '{key_right,  6'd6, 6'd18, 6'd5, 6'd20, 1'b0};   // turn right
    rows[13] = '{key_up,     6'd7, 6'd18, 6'd5, 6'd19, 1'b0};   // locked
    rows[14] = '{8'h00,      6'd8, 6'd18, 6'd5, 6'd18, 1'b0};
    rows[15] = '{8'h00,      6'd9, 6'd18, 6'd6, 6'd18, 1'b0};
    rows[16] = '{key_down,   6'd9, 6'd19, 6'd7, 6'd18, 1'b0};   // turn down
    rows[17] = '{8'h00,      6'd9, 6'd20, 6'd8, 6'd18, 1'b0};
    rows[18] = '{8'h00,      6'd9, 6'd21, 6'd9, 6'd18, 1'b0};
    rows[19] = '{8'h00,      6'd9, 6'd22, 6'd9, 6'd19, 1'b0};
    rows[20] = '{key_pause,  6'd9, 6'd23, 6'd9, 6'd20, 1'b0};   // last step before pause
    rows[21] = '{8'h00,      6'd9, 6'd23, 6'd9, 6'd20, 1'b0};
    rows[22] = '{key_left,   6'd9, 6'd23, 6'd9, 6'd20, 1'b0};   // arrow while paused
    rows[23] = '{8'h00,      6'd9, 6'd23, 6'd9, 6'd20, 1'b0};
    rows[24] = '{key_resume, 6'd9, 6'd23, 6'd9, 6'd20, 1'b0};
    rows[25] = '{8'h00,      6'd9, 6'd24, 6'd9, 6'd21, 1'b0};   // still heading down
    rows[26] = '{key_escape, 6'd9, 6'd24, 6'd9, 6'd21, 1'b1};
    rows[27] = '{8'h00,      6'd9, 6'd24, 6'd9, 6'd21, 1'b1};
    rows[28] = '{key_right,  6'd9, 6'd24, 6'd9, 6'd21, 1'b1};
    rows[29] = '{key_start,  6'd3, 6'd23, 6'd0, 6'd23, 1'b0};   // reload start row
    rows[30] = '{8'h00,      6'd3, 6'd23, 6'd0, 6'd23, 1'b0};
    rows[31] = '{8'h00,      6'd4, 6'd23, 6'd1, 6'd23, 1'b0};
endtask

// ==== bench/snake_tb.sv ====
// Snake game controller testbench
`timescale 1ns/1ps

module snake_tb import snake_pkg::*; ();

    localparam int tick_div   = 8;
    localparam int max_wait   = 4 * tick_div;
    localparam int num_rows   = 32;
    localparam int free_ticks = 64;     // enough to wrap x once
    localparam int rand_ticks = 48;

    typedef struct packed {
        scan_code_t key;
        coord_t     head_x;
        coord_t     head_y;
        coord_t     tail_x;
        coord_t     tail_y;
        logic       blank;
    } row_t;

    logic                     main_clk;
    logic                     rst;
    scan_code_t               key_code;
    logic                     key_valid;
    segment_t [snake_len-1:0] segments;
    logic                     blank;
    logic                     frame_valid;

    row_t   rows [num_rows];
    int     errors;
    int     timeouts;
    logic   timed_out;
    integer seed;

    // reference model, index 0 is the head
    coord_t      ref_x [snake_len];
    coord_t      ref_y [snake_len];
    game_state_t ref_state;
    direction_t  ref_dir;
    int          ref_lock;
    logic        ref_blank;

    `include "snake_tb_table.svh"

    snake_top #(
        .tick_div (tick_div)
    ) uut (
        .main_clk    (main_clk),
        .rst         (rst),
        .key_code    (key_code),
        .key_valid   (key_valid),
        .segments    (segments),
        .blank       (blank),
        .frame_valid (frame_valid)
    );

    initial begin
        main_clk = 1'b0;
        forever #2 main_clk = ~main_clk;
    end

    task automatic load_row(input coord_t row);
        for (int i = 0; i < snake_len; i++) begin
            ref_x[i] = coord_t'(snake_len - 1 - i);
            ref_y[i] = row;
        end
    endtask

    function automatic logic vertical(input direction_t d);
        return (d == dir_up) || (d == dir_down);
    endfunction

    task automatic move_head();
        for (int i = snake_len - 1; i > 0; i--) begin
            ref_x[i] = ref_x[i-1];
            ref_y[i] = ref_y[i-1];
        end
        case (ref_dir)
            dir_up:    ref_y[0] = ref_y[0] - 6'd1;
            dir_down:  ref_y[0] = ref_y[0] + 6'd1;
            dir_left:  ref_x[0] = ref_x[0] - 6'd1;
            default:   ref_x[0] = ref_x[0] + 6'd1;
        endcase
    endtask

    task automatic model_tick(input scan_code_t key);
        logic       arrow;
        direction_t want;
        arrow = 1'b1;
        want  = ref_dir;
        case (key)
            key_up:    want = dir_up;
            key_down:  want = dir_down;
            key_left:  want = dir_left;
            key_right: want = dir_right;
            default:   arrow = 1'b0;
        endcase
        if (key == key_escape) begin
            ref_state = st_blank;
            ref_blank = 1'b1;
        end else if (key == key_start) begin
            ref_state = st_start;
            ref_blank = 1'b0;
            load_row(start_row);
        end else begin
            case (ref_state)
                st_idle: load_row(idle_row);
                st_start: begin
                    ref_state = st_run;     // no move on this tick
                    ref_dir   = dir_right;
                    ref_lock  = 0;
                end
                st_run: begin
                    if (ref_lock > 0) begin
                        ref_lock--;
                    end else if (key == key_pause) begin
                        ref_state = st_pause;
                    end else if (arrow && vertical(want) != vertical(ref_dir)) begin
                        ref_dir  = want;
                        ref_lock = turn_lock_steps;
                    end
                    move_head();
                end
                st_pause: begin
                    if (key == key_resume) begin
                        ref_state = st_run;
                    end
                end
                default: ;
            endcase
        end
    endtask

    task automatic send_key(input scan_code_t key);
        if (key != 8'h00) begin
            key_code  = key;
            key_valid = 1'b1;
            @(posedge main_clk);
            #1;
            key_valid = 1'b0;
            key_code  = 8'h00;
        end
    endtask

    task automatic wait_frame();
        int n;
        n = 0;
        do begin
            @(posedge main_clk);
            #1;
            n++;
        end while (!frame_valid && n < max_wait);
        assert (frame_valid) else begin
            timeouts++;
            timed_out = 1'b1;
            $display("timeout: no frame_valid pulse within %0d cycles", max_wait);
        end
    endtask

    task automatic expect_equal(input string name, input int tick,
                                input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("FAIL tick %0d %s: got %h expected %h", tick, name, got, exp);
        end
    endtask

    task automatic check_frame(input int tick);
        for (int i = 0; i < snake_len; i++) begin
            expect_equal($sformatf("segments[%0d].x", i), tick, segments[i].x, ref_x[i]);
            expect_equal($sformatf("segments[%0d].y", i), tick, segments[i].y, ref_y[i]);
        end
        expect_equal("blank", tick, blank, ref_blank);
    endtask

    task automatic check_row(input int r, input int tick);
        expect_equal("segments[0].x", tick, segments[0].x, rows[r].head_x);
        expect_equal("segments[0].y", tick, segments[0].y, rows[r].head_y);
        expect_equal("segments[3].x", tick, segments[snake_len-1].x, rows[r].tail_x);
        expect_equal("segments[3].y", tick, segments[snake_len-1].y, rows[r].tail_y);
        expect_equal("blank", tick, blank, rows[r].blank);
    endtask

    initial begin
        int         tick;
        int         sel;
        coord_t     prev_x;
        logic       saw_wrap;
        scan_code_t key;
        errors    = 0;
        timeouts  = 0;
        timed_out = 1'b0;
        seed      = 32'h10a0_13e3;
        tick      = 0;
        saw_wrap  = 1'b0;
        rst       = 1'b1;
        key_code  = 8'h00;
        key_valid = 1'b0;
        ref_state = st_idle;
        ref_dir   = dir_right;
        ref_lock  = 0;
        ref_blank = 1'b0;
        load_row(idle_row);
        fill_table();
        repeat (2) @(posedge main_clk);
        #1;
        rst = 1'b0;

        for (int r = 0; r < num_rows && !timed_out; r++) begin
            send_key(rows[r].key);
            wait_frame();
            if (!timed_out) begin
                model_tick(rows[r].key);
                check_frame(tick);
                check_row(r, tick);
            end
            tick++;
        end

        // no keys, snake keeps heading right across the edge
        for (int n = 0; n < free_ticks && !timed_out; n++) begin
            prev_x = segments[0].x;
            wait_frame();
            if (!timed_out) begin
                model_tick(8'h00);
                check_frame(tick);
                if (prev_x == 6'd63 && segments[0].x == 6'd0) begin
                    saw_wrap = 1'b1;
                end
            end
            tick++;
        end
        if (!timed_out) begin
            assert (saw_wrap) else begin
                errors++;
                $display("head x never wrapped from 63 to 0 while moving right");
            end
        end

        for (int n = 0; n < rand_ticks && !timed_out; n++) begin
            sel = {$random(seed)} % 5;
            case (sel)
                0:       key = key_up;
                1:       key = key_down;
                2:       key = key_left;
                3:       key = key_right;
                default: key = 8'h00;
            endcase
            send_key(key);
            wait_frame();
            if (!timed_out) begin
                model_tick(key);
                check_frame(tick);
            end
            tick++;
        end

        $display("errors: %0d failed checks, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== source/game_fsm.sv ====
// Game state machine
`timescale 1ns/1ps

module game_fsm import snake_pkg::*; (
    input  logic       main_clk,
    input  logic       rst,
    input  logic       game_tick,
    input  command_t   pending_cmd,
    output body_ctrl_t body_ctrl,
    output logic       blank
);

    localparam int lock_w = $clog2(turn_lock_steps + 1);

    game_state_t       state;
    game_state_t       state_nxt;
    direction_t        dir;
    direction_t        dir_nxt;
    logic [lock_w-1:0] lock_cnt;
    logic [lock_w-1:0] lock_nxt;
    logic              blank_nxt;
    body_ctrl_t        ctrl;
    logic              arrow;
    direction_t        arrow_to;
    logic              turn_ok;

    always_comb begin
        arrow    = 1'b1;
        arrow_to = dir;
        case (pending_cmd)
            cmd_up:    arrow_to = dir_up;
            cmd_down:  arrow_to = dir_down;
            cmd_left:  arrow_to = dir_left;
            cmd_right: arrow_to = dir_right;
            default:   arrow    = 1'b0;
        endcase
    end

    assign turn_ok = arrow && (arrow_to[1] != dir[1]);  // other axis only

    always_comb begin
        state_nxt  = state;
        dir_nxt    = dir;
        lock_nxt   = lock_cnt;
        blank_nxt  = blank;
        ctrl       = '0;
        ctrl.frame = 1'b1;
        ctrl.dir   = dir;
        if (pending_cmd == cmd_escape) begin
            state_nxt = st_blank;
            blank_nxt = 1'b1;
        end else if (pending_cmd == cmd_start) begin
            state_nxt       = st_start;
            blank_nxt       = 1'b0;
            ctrl.load_start = 1'b1;
        end else begin
            case (state)
                st_idle: begin
                    ctrl.load_idle = 1'b1;
                end
                st_blank: begin
                    state_nxt = st_blank;       // wait for start
                end
                st_start: begin
                    state_nxt = st_run;         // hold start row one more frame
                    dir_nxt   = dir_right;
                    lock_nxt  = '0;
                end
                st_run: begin
                    ctrl.step = 1'b1;
                    if (lock_cnt != '0) begin
                        lock_nxt = lock_cnt - 1'b1;     // still locked after turn
                    end else if (pending_cmd == cmd_pause) begin
                        state_nxt = st_pause;
                    end else if (turn_ok) begin
                        dir_nxt  = arrow_to;
                        ctrl.dir = arrow_to;
                        lock_nxt = lock_w'(turn_lock_steps);
                    end
                end
                st_pause: begin
                    if (pending_cmd == cmd_resume) begin
                        state_nxt = st_run;
                    end
                end
                default: begin
                    state_nxt = st_idle;
                end
            endcase
        end
    end

    assign body_ctrl = game_tick ? ctrl : '0;

    always_ff @(posedge main_clk) begin
        if (rst) begin
            state    <= st_idle;
            dir      <= dir_right;
            lock_cnt <= '0;
            blank    <= 1'b0;
        end else if (game_tick) begin
            state    <= state_nxt;
            dir      <= dir_nxt;
            lock_cnt <= lock_nxt;
            blank    <= blank_nxt;
        end
    end

endmodule

// ==== source/key_decoder.sv ====
// Keyboard command decoder
`timescale 1ns/1ps

module key_decoder import snake_pkg::*; (
    input  logic       main_clk,
    input  logic       rst,
    input  scan_code_t key_code,
    input  logic       key_valid,
    input  logic       game_tick,
    output command_t   pending_cmd
);

    command_t key_cmd;

    always_comb begin
        case (key_code)
            key_start:  key_cmd = cmd_start;
            key_escape: key_cmd = cmd_escape;
            key_pause:  key_cmd = cmd_pause;
            key_resume: key_cmd = cmd_resume;
            key_up:     key_cmd = cmd_up;
            key_down:   key_cmd = cmd_down;
            key_left:   key_cmd = cmd_left;
            key_right:  key_cmd = cmd_right;
            default:    key_cmd = cmd_none;     // unknown code
        endcase
    end

    // a key in the tick cycle survives for the next tick
    always_ff @(posedge main_clk) begin
        if (rst) begin
            pending_cmd <= cmd_none;
        end else if (key_valid && key_cmd != cmd_none) begin
            pending_cmd <= key_cmd;             // latest key wins
        end else if (game_tick) begin
            pending_cmd <= cmd_none;            // consumed by fsm
        end
    end

endmodule

// ==== source/segment_order.sv ====
// Head-first segment output
`timescale 1ns/1ps

module segment_order import snake_pkg::*; (
    input  logic                     main_clk,
    input  logic                     rst,
    input  segment_t [snake_len-1:0] slots,
    input  seg_index_t               head_ptr,
    input  logic                     body_step,
    output segment_t [snake_len-1:0] segments,
    output logic                     frame_valid
);

    segment_t [snake_len-1:0] ordered;

    // walk backwards from the head, wrapping in the ring
    always_comb begin
        seg_index_t idx;
        for (int i = 0; i < snake_len; i++) begin
            idx        = head_ptr - seg_index_t'(i);
            ordered[i] = slots[idx];
        end
    end

    always_ff @(posedge main_clk) begin
        if (body_step) begin
            segments <= ordered;
        end
    end

    always_ff @(posedge main_clk) begin
        if (rst) begin
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= body_step;   // one pulse per tick
        end
    end

endmodule

// ==== source/snake_body.sv ====
// Snake body ring buffer
`timescale 1ns/1ps

module snake_body import snake_pkg::*; (
    input  logic                     main_clk,
    input  logic                     rst,
    input  body_ctrl_t               body_ctrl,
    output segment_t [snake_len-1:0] slots,
    output seg_index_t               head_ptr,
    output logic                     body_step
);

    seg_index_t tail_ptr;
    segment_t   head_nxt;
    logic       load;
    coord_t     load_row;

    assign tail_ptr = head_ptr + 1'b1;      // tail sits right after the head
    assign load     = body_ctrl.load_idle || body_ctrl.load_start;
    assign load_row = body_ctrl.load_start ? start_row : idle_row;

    always_comb begin
        head_nxt = slots[head_ptr];
        case (body_ctrl.dir)
            dir_up:    head_nxt.y = slots[head_ptr].y - 1'b1;
            dir_down:  head_nxt.y = slots[head_ptr].y + 1'b1;
            dir_left:  head_nxt.x = slots[head_ptr].x - 1'b1;
            default:   head_nxt.x = slots[head_ptr].x + 1'b1;
        endcase
    end

    always_ff @(posedge main_clk) begin
        if (rst || load) begin
            for (int i = 0; i < snake_len; i++) begin
                slots[i] <= '{x: coord_t'(i), y: rst ? idle_row : load_row};
            end
            head_ptr <= seg_index_t'(snake_len - 1);   // head at x 3
        end else if (body_ctrl.step) begin
            slots[tail_ptr] <= head_nxt;        // old tail becomes new head
            head_ptr        <= tail_ptr;
        end
    end

    always_ff @(posedge main_clk) begin
        if (rst) begin
            body_step <= 1'b0;
        end else begin
            body_step <= body_ctrl.frame;
        end
    end

endmodule

// ==== source/snake_pkg.sv ====
// Snake game shared types
package snake_pkg;

    typedef logic [5:0] coord_t;      // grid wraps mod 64
    typedef logic [7:0] scan_code_t;
    typedef logic [1:0] seg_index_t;

    localparam scan_code_t key_start  = 8'h1b;
    localparam scan_code_t key_escape = 8'h76;
    localparam scan_code_t key_pause  = 8'h4d;
    localparam scan_code_t key_resume = 8'h2d;
    localparam scan_code_t key_up     = 8'h75;
    localparam scan_code_t key_down   = 8'h72;
    localparam scan_code_t key_right  = 8'h74;
    localparam scan_code_t key_left   = 8'h6b;

    typedef enum logic [3:0] {
        cmd_none,
        cmd_start,
        cmd_escape,
        cmd_pause,
        cmd_resume,
        cmd_up,
        cmd_down,
        cmd_left,
        cmd_right
    } command_t;

    // bit 1 set means horizontal
    typedef enum logic [1:0] {
        dir_up,     // y - 1
        dir_down,   // y + 1
        dir_left,   // x - 1
        dir_right   // x + 1
    } direction_t;

    typedef enum logic [2:0] {
        st_idle,
        st_blank,
        st_start,
        st_run,
        st_pause
    } game_state_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } segment_t;

    typedef struct packed {
        logic       frame;      // tick seen, publish a frame
        logic       load_idle;
        logic       load_start;
        logic       step;
        direction_t dir;
    } body_ctrl_t;

    localparam int     snake_len       = 4;
    localparam coord_t idle_row        = 6'd48;
    localparam coord_t start_row       = 6'd23;
    localparam int     turn_lock_steps = 3;

endpackage

// ==== source/snake_top.sv ====
// Snake game controller top
`timescale 1ns/1ps

module snake_top import snake_pkg::*; #(
    parameter int unsigned tick_div = 10_000_000
) (
    input  logic                     main_clk,
    input  logic                     rst,
    input  scan_code_t               key_code,
    input  logic                     key_valid,
    output segment_t [snake_len-1:0] segments,
    output logic                     blank,
    output logic                     frame_valid
);

    logic                     game_tick;
    command_t                 pending_cmd;
    body_ctrl_t               body_ctrl;
    segment_t [snake_len-1:0] slots;
    seg_index_t               head_ptr;
    logic                     body_step;

    tick_gen #(
        .tick_div (tick_div)
    ) u_tick_gen (
        .main_clk  (main_clk),
        .rst       (rst),
        .game_tick (game_tick)
    );

    key_decoder u_key_decoder (
        .main_clk    (main_clk),
        .rst         (rst),
        .key_code    (key_code),
        .key_valid   (key_valid),
        .game_tick   (game_tick),
        .pending_cmd (pending_cmd)
    );

    game_fsm u_game_fsm (
        .main_clk    (main_clk),
        .rst         (rst),
        .game_tick   (game_tick),
        .pending_cmd (pending_cmd),
        .body_ctrl   (body_ctrl),
        .blank       (blank)
    );

    snake_body u_snake_body (
        .main_clk  (main_clk),
        .rst       (rst),
        .body_ctrl (body_ctrl),
        .slots     (slots),
        .head_ptr  (head_ptr),
        .body_step (body_step)
    );

    segment_order u_segment_order (
        .main_clk    (main_clk),
        .rst         (rst),
        .slots       (slots),
        .head_ptr    (head_ptr),
        .body_step   (body_step),
        .segments    (segments),
        .frame_valid (frame_valid)
    );

endmodule

// ==== source/tick_gen.sv ====
// Game tick generator
`timescale 1ns/1ps

module tick_gen #(
    parameter int unsigned tick_div = 10_000_000
) (
    input  logic main_clk,
    input  logic rst,
    output logic game_tick
);

    localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [cnt_w-1:0] cnt;
    logic             last;

    assign last = (cnt == cnt_w'(tick_div - 1));

    always_ff @(posedge main_clk) begin
        if (rst) begin
            cnt       <= '0;
            game_tick <= 1'b0;
        end else begin
            game_tick <= last;                      // one pulse per period
            cnt       <= last ? '0 : cnt + 1'b1;
        end
    end

endmodule

// ==== verilog.f ====
+incdir+bench
source/snake_pkg.sv
source/tick_gen.sv
source/key_decoder.sv
source/game_fsm.sv
source/snake_body.sv
source/segment_order.sv
source/snake_top.sv
bench/snake_tb.sv
